// File: ex_unit.f
+incdir+include
verilog/ex_unit_pkg.sv
verilog/ex_unit_wb_regs.sv
verilog/ex_unit_int_alu.sv
verilog/ex_unit_bitmanip.sv
verilog/ex_unit_result.sv
verilog/ex_unit.sv
test/ex_unit_tb.sv

// File: include/ex_unit_macros.svh
`ifndef EX_UNIT_MACROS_SVH
`define EX_UNIT_MACROS_SVH

// Width of operands, results and Wishbone data
`define EX_UNIT_XLEN 32

// Wishbone word address width
`define EX_UNIT_AW 3

// Register map in word addresses
`define EX_UNIT_REG_OPA  3'd0
`define EX_UNIT_REG_OPB  3'd1
`define EX_UNIT_REG_OP   3'd2
// Read only
`define EX_UNIT_REG_RES  3'd3
`define EX_UNIT_REG_STAT 3'd4

`endif

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f ex_unit.f --top-module ex_unit_tb \
  -o ex_unit_sim > build.log 2>&1 \
  && ./obj_dir/ex_unit_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation aborted"; exit 1; }

cat sim.log
grep -qF "*** TEST PASSED ***" sim.log && exit 0 || exit 1

// File: test/ex_unit_patterns.txt
// Columns: operation code, operand A, operand B, expected RES, expected branch bit
// All fields hex, one test per line
// Integer ALU
00 00000005 00000003 00000008 1
01 00000003 00000005 fffffffe 1
02 f0f0f0f0 ff00ff00 0ff00ff0 1
04 f0f0f0f0 ff00ff00 f000f000 1
05 f0f0f0f0 ff00ff00 00f000f0 1
06 00000000 ff00ff00 00ff00ff 1
07 f0f0f0f0 ff00ff00 f00ff00f 1
08 12345678 00000024 23456780 1
09 80000000 0000001f 00000001 1
0a 80000000 00000004 f8000000 1
0b ffffffff 00000001 00000001 1
0c ffffffff 00000001 00000000 1
0d 00000010 00000001 00000021 1
0e 00000010 00000001 00000041 1
0f 00000010 00000001 00000081 1
// Branch compares
10 12345678 12345678 00000000 1
10 12345678 12345679 00000000 0
11 00000000 80000000 00000000 1
12 80000000 7fffffff 00000000 1
13 80000000 7fffffff 00000000 0
13 00000000 ffffffff 00000000 1
14 7fffffff 80000000 00000000 1
14 ffffffff 00000000 00000000 0
15 ffffffff 00000000 00000000 1
// Bit manipulation
20 ffffffff 00000001 00000001 1
21 ffffffff 00000001 ffffffff 1
22 ffffffff 00000001 ffffffff 1
23 ffffffff 00000001 00000001 1
24 00010000 00000000 0000000f 1
24 00000000 00000000 00000020 1
25 00010000 00000000 00000010 1
25 00000000 00000000 00000020 1
26 f0f0000f 00000000 0000000c 1
27 00000080 00000000 ffffff80 1
28 12348001 00000000 ffff8001 1
29 ffff1234 00000000 00001234 1
2a 80000001 00000004 00000018 1
2a 12345678 00000020 12345678 1
2b 80000001 00000004 18000000 1
2c 00120300 00000000 00ffff00 1
2d 12345678 00000000 78563412 1
2e 00000000 0000001f 80000000 1
2f ffffffff 00000000 fffffffe 1
30 0000000f 00000003 00000007 1
31 00000100 00000008 00000001 1
31 00000100 00000009 00000000 1
// Conditional zero
32 deadbeef 00000000 00000000 1
32 deadbeef 00000001 deadbeef 1
33 deadbeef 00000000 deadbeef 1
33 deadbeef 80000000 00000000 1

// File: test/ex_unit_tb.sv
`include "ex_unit_macros.svh"

module ex_unit_tb;

  localparam int MAX_PATTERNS = 64;
  localparam int WORDS        = 5;

  logic                       clk;
  logic                       reset;
  logic                       wb_cyc;
  logic                       wb_stb;
  logic                       wb_we;
  logic [`EX_UNIT_AW-1:0]     wb_adr;
  logic [`EX_UNIT_XLEN-1:0]   wb_dat_w;
  logic [`EX_UNIT_XLEN/8-1:0] wb_sel;
  logic [`EX_UNIT_XLEN-1:0]   wb_dat_r;
  logic                       wb_ack;

  // Five words per line of the pattern file
  logic [`EX_UNIT_XLEN-1:0] pattern_mem [WORDS*MAX_PATTERNS];

  int num_patterns;
  int cycle_limit;
  int cycles;
  int errors;
  int errors_at_start;
  int pass_count;
  int fail_count;

  ex_unit ex_unit_i (
    .clk_i    (clk),
    .reset_i  (reset),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_sel_i (wb_sel),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack)
  );

  always #4 clk = ~clk;

  // Watchdog, armed once the pattern count is known
  initial begin
    cycles = 0;
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // ---------------------------------------------------------------------
  // Wishbone master
  // ---------------------------------------------------------------------
  task automatic idle_gap();
    repeat ($urandom_range(3, 0)) @(posedge clk);
  endtask

  // Request held until ack is seen, dropped on the next edge
  task automatic bus_cycle(input logic we, input logic [`EX_UNIT_AW-1:0] adr,
                           input logic [`EX_UNIT_XLEN-1:0] wdata,
                           input logic [`EX_UNIT_XLEN/8-1:0] sel,
                           output logic [`EX_UNIT_XLEN-1:0] rdata);
    idle_gap();
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    wb_sel   <= sel;
    do begin
      @(negedge clk);
    end while (wb_ack !== 1'b1);
    rdata = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic write_reg(input logic [`EX_UNIT_AW-1:0] adr,
                           input logic [`EX_UNIT_XLEN-1:0] data,
                           input logic [`EX_UNIT_XLEN/8-1:0] sel);
    logic [`EX_UNIT_XLEN-1:0] unused;
    bus_cycle(1'b1, adr, data, sel, unused);
  endtask

  task automatic read_reg(input logic [`EX_UNIT_AW-1:0] adr,
                          output logic [`EX_UNIT_XLEN-1:0] data);
    bus_cycle(1'b0, adr, '0, '1, data);
  endtask

  // ---------------------------------------------------------------------
  // Checks and reporting
  // ---------------------------------------------------------------------
  task automatic check_value(input string name, input logic [`EX_UNIT_XLEN-1:0] got,
                             input logic [`EX_UNIT_XLEN-1:0] expected);
    assert (got === expected) else begin
      $display("ERR %s got %h expected %h", name, got, expected);
      errors++;
    end
  endtask

  task automatic close_test(input string label);
    if (errors == errors_at_start) begin
      pass_count++;
      $display("%s: ok", label);
    end else begin
      fail_count++;
      $display("%s: failed", label);
    end
    errors_at_start = errors;
  endtask

  task automatic check_register_protocol();
    logic [`EX_UNIT_XLEN-1:0] got;
    read_reg(`EX_UNIT_REG_STAT, got);
    check_value("STAT", got, '0);
    close_test("status after reset");

    // Lanes 0 and 2 overwritten, lanes 1 and 3 kept
    write_reg(`EX_UNIT_REG_OPA, 32'h1122_3344, 4'b1111);
    write_reg(`EX_UNIT_REG_OPA, 32'haabb_ccdd, 4'b0101);
    read_reg(`EX_UNIT_REG_OPA, got);
    check_value("OPA", got, 32'h11bb_33dd);
    write_reg(`EX_UNIT_REG_OPB, 32'h5566_7788, 4'b1010);
    read_reg(`EX_UNIT_REG_OPB, got);
    check_value("OPB", got, 32'h5500_7700);
    close_test("operand byte enables");

    write_reg(`EX_UNIT_REG_OP, 32'(ex_unit_pkg::ADD), '1);
    read_reg(`EX_UNIT_REG_RES, got);
    check_value("RES", got, 32'h66bb_aadd);
    read_reg(`EX_UNIT_REG_STAT, got);
    check_value("STAT", got & 32'h1, 32'h1);
    write_reg(`EX_UNIT_REG_OPA, 32'h0000_0001, '1);
    read_reg(`EX_UNIT_REG_STAT, got);
    check_value("STAT", got & 32'h1, 32'h0);
    close_test("done cleared by operand write");

    // 0x3c lies outside both code ranges
    write_reg(`EX_UNIT_REG_OP, 32'h0000_003c, '1);
    read_reg(`EX_UNIT_REG_RES, got);
    check_value("RES", got, '0);
    read_reg(`EX_UNIT_REG_STAT, got);
    check_value("STAT", got & 32'h5, 32'h5);
    close_test("illegal operation");

    // Data opposite to the current contents of both registers
    write_reg(`EX_UNIT_REG_RES, 32'hffff_ffff, '1);
    write_reg(`EX_UNIT_REG_STAT, 32'h0000_0000, '1);
    read_reg(`EX_UNIT_REG_RES, got);
    check_value("RES", got, '0);
    read_reg(`EX_UNIT_REG_STAT, got);
    check_value("STAT", got & 32'h5, 32'h5);
    close_test("read-only registers ignore writes");
  endtask

  task automatic run_pattern(input int idx);
    logic [5:0]               op;
    logic [`EX_UNIT_XLEN-1:0] opa;
    logic [`EX_UNIT_XLEN-1:0] opb;
    logic [`EX_UNIT_XLEN-1:0] exp_res;
    logic                     exp_branch;
    logic [`EX_UNIT_XLEN-1:0] got;
    op         = pattern_mem[WORDS*idx][5:0];
    opa        = pattern_mem[WORDS*idx+1];
    opb        = pattern_mem[WORDS*idx+2];
    exp_res    = pattern_mem[WORDS*idx+3];
    exp_branch = pattern_mem[WORDS*idx+4][0];
    write_reg(`EX_UNIT_REG_OPA, opa, '1);
    write_reg(`EX_UNIT_REG_OPB, opb, '1);
    write_reg(`EX_UNIT_REG_OP, {{(`EX_UNIT_XLEN-6){1'b0}}, op}, '1);
    read_reg(`EX_UNIT_REG_RES, got);
    check_value("RES", got, exp_res);
    read_reg(`EX_UNIT_REG_STAT, got);
    // Done set, illegal clear
    check_value("STAT", got, {{(`EX_UNIT_XLEN-3){1'b0}}, 1'b0, exp_branch, 1'b1});
    close_test($sformatf("pattern %0d op %h", idx, op));
  endtask

  // ---------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------
  initial begin
    clk             = 1'b0;
    reset           = 1'b1;
    wb_cyc          = 1'b0;
    wb_stb          = 1'b0;
    wb_we           = 1'b0;
    wb_adr          = '0;
    wb_dat_w        = '0;
    wb_sel          = '0;
    errors          = 0;
    errors_at_start = 0;
    pass_count      = 0;
    fail_count      = 0;
    void'($urandom(32'hd8066f64));

    // Unused words keep nonzero upper bits, which ends the count
    for (int i = 0; i < WORDS*MAX_PATTERNS; i++) begin
      pattern_mem[i] = 32'hffff_0000 | i;
    end
    $readmemh("test/ex_unit_patterns.txt", pattern_mem);
    num_patterns = 0;
    while (num_patterns < MAX_PATTERNS &&
           pattern_mem[WORDS*num_patterns][`EX_UNIT_XLEN-1:6] == '0) begin
      num_patterns++;
    end
    if (num_patterns == 0) begin
      $display("No test lines could be read from test/ex_unit_patterns.txt");
      errors++;
    end
    cycle_limit = num_patterns * 40 + 100;

    repeat (2) @(posedge clk);
    reset <= 1'b0;

    check_register_protocol();
    for (int i = 0; i < num_patterns; i++) begin
      run_pattern(i);
    end

    $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0 && errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: verilog/ex_unit.sv
`include "ex_unit_macros.svh"

module ex_unit (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  logic [`EX_UNIT_AW-1:0]     wb_adr_i,
  input  logic [`EX_UNIT_XLEN-1:0]   wb_dat_i,
  input  logic [`EX_UNIT_XLEN/8-1:0] wb_sel_i,
  output logic [`EX_UNIT_XLEN-1:0]   wb_dat_o,
  output logic                       wb_ack_o
);

  logic [`EX_UNIT_XLEN-1:0] operand_a;
  logic [`EX_UNIT_XLEN-1:0] operand_b;
  ex_unit_pkg::alu_op_e     operation;
  logic                     start;
  logic                     clear;
  logic [`EX_UNIT_XLEN-1:0] int_result;
  logic                     branch_res;
  logic [`EX_UNIT_XLEN-1:0] bm_result;
  logic [`EX_UNIT_XLEN-1:0] result;
  logic [`EX_UNIT_XLEN-1:0] status;

  ex_unit_wb_regs wb_regs_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_sel_i    (wb_sel_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .result_i    (result),
    .status_i    (status),
    .operand_a_o (operand_a),
    .operand_b_o (operand_b),
    .operation_o (operation),
    .start_o     (start),
    .clear_o     (clear)
  );

  // Both units see the same operands
  ex_unit_int_alu int_alu_i (
    .operand_a_i  (operand_a),
    .operand_b_i  (operand_b),
    .operation_i  (operation),
    .result_o     (int_result),
    .branch_res_o (branch_res)
  );

  ex_unit_bitmanip bitmanip_i (
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .operation_i (operation),
    .result_o    (bm_result)
  );

  ex_unit_result result_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .start_i      (start),
    .clear_i      (clear),
    .operation_i  (operation),
    .int_result_i (int_result),
    .branch_res_i (branch_res),
    .bm_result_i  (bm_result),
    .result_o     (result),
    .status_o     (status)
  );

endmodule

// File: verilog/ex_unit_bitmanip.sv
`include "ex_unit_macros.svh"

module ex_unit_bitmanip (
  input  logic [`EX_UNIT_XLEN-1:0] operand_a_i,
  input  logic [`EX_UNIT_XLEN-1:0] operand_b_i,
  input  ex_unit_pkg::alu_op_e     operation_i,
  output logic [`EX_UNIT_XLEN-1:0] result_o
);

  // Counter width, holds 0 to XLEN
  localparam int CW = $clog2(`EX_UNIT_XLEN) + 1;

  logic                     cmp_signed;
  logic                     less;
  logic [4:0]               shamt;
  logic [`EX_UNIT_XLEN-1:0] bit_idx;
  logic [`EX_UNIT_XLEN-1:0] rol_res;
  logic [`EX_UNIT_XLEN-1:0] ror_res;
  logic [`EX_UNIT_XLEN-1:0] orcb_res;
  logic [`EX_UNIT_XLEN-1:0] rev8_res;
  logic [CW-1:0]            clz_cnt;
  logic [CW-1:0]            ctz_cnt;
  logic [CW-1:0]            cpop_cnt;

  // Min/max compare
  assign cmp_signed = (operation_i == ex_unit_pkg::MIN) || (operation_i == ex_unit_pkg::MAX);
  assign less = $signed({cmp_signed & operand_a_i[`EX_UNIT_XLEN-1], operand_a_i}) <
                $signed({cmp_signed & operand_b_i[`EX_UNIT_XLEN-1], operand_b_i});

  // Rotate amount and single-bit index
  assign shamt   = operand_b_i[4:0];
  assign bit_idx = {{(`EX_UNIT_XLEN-1){1'b0}}, 1'b1} << shamt;

  // A zero amount shifts the second term out entirely
  assign rol_res = (operand_a_i << shamt) | (operand_a_i >> (`EX_UNIT_XLEN - shamt));
  assign ror_res = (operand_a_i >> shamt) | (operand_a_i << (`EX_UNIT_XLEN - shamt));

  // -------------------------------------------------------------------
  // Bit counting
  // -------------------------------------------------------------------
  // Last hit wins, so the scan order picks the outermost set bit
  always_comb begin
    clz_cnt  = CW'(`EX_UNIT_XLEN);
    ctz_cnt  = CW'(`EX_UNIT_XLEN);
    cpop_cnt = '0;
    for (int i = 0; i < `EX_UNIT_XLEN; i++) begin
      if (operand_a_i[i]) begin
        clz_cnt = CW'(`EX_UNIT_XLEN - 1 - i);
      end
      if (operand_a_i[`EX_UNIT_XLEN-1-i]) begin
        ctz_cnt = CW'(`EX_UNIT_XLEN - 1 - i);
      end
      cpop_cnt = cpop_cnt + CW'(operand_a_i[i]);
    end
  end

  // Byte-wise OR-combine and byte reverse
  always_comb begin
    for (int i = 0; i < `EX_UNIT_XLEN/8; i++) begin
      orcb_res[8*i +: 8] = {8{|operand_a_i[8*i +: 8]}};
      rev8_res[8*i +: 8] = operand_a_i[`EX_UNIT_XLEN-8-8*i +: 8];
    end
  end

  // -------------------------------------------------------------------
  // Result mux
  // -------------------------------------------------------------------
  always_comb begin
    case (operation_i)
      ex_unit_pkg::MAX, ex_unit_pkg::MAXU: result_o = less ? operand_b_i : operand_a_i;
      ex_unit_pkg::MIN, ex_unit_pkg::MINU: result_o = less ? operand_a_i : operand_b_i;
      ex_unit_pkg::CLZ:  result_o = {{(`EX_UNIT_XLEN-CW){1'b0}}, clz_cnt};
      ex_unit_pkg::CTZ:  result_o = {{(`EX_UNIT_XLEN-CW){1'b0}}, ctz_cnt};
      ex_unit_pkg::CPOP: result_o = {{(`EX_UNIT_XLEN-CW){1'b0}}, cpop_cnt};
      ex_unit_pkg::SEXTB: result_o = {{(`EX_UNIT_XLEN-8){operand_a_i[7]}}, operand_a_i[7:0]};
      ex_unit_pkg::SEXTH: result_o = {{(`EX_UNIT_XLEN-16){operand_a_i[15]}}, operand_a_i[15:0]};
      ex_unit_pkg::ZEXTH: result_o = {{(`EX_UNIT_XLEN-16){1'b0}}, operand_a_i[15:0]};
      ex_unit_pkg::ROL:  result_o = rol_res;
      ex_unit_pkg::ROR:  result_o = ror_res;
      ex_unit_pkg::ORCB: result_o = orcb_res;
      ex_unit_pkg::REV8: result_o = rev8_res;
      ex_unit_pkg::BSET: result_o = operand_a_i | bit_idx;
      ex_unit_pkg::BCLR: result_o = operand_a_i & ~bit_idx;
      ex_unit_pkg::BINV: result_o = operand_a_i ^ bit_idx;
      ex_unit_pkg::BEXT: result_o = {{(`EX_UNIT_XLEN-1){1'b0}}, |(operand_a_i & bit_idx)};
      // Zero when B is zero, else A
      ex_unit_pkg::CZERO_EQZ: result_o = (|operand_b_i) ? operand_a_i : '0;
      // Zero when B is nonzero, else A
      ex_unit_pkg::CZERO_NEZ: result_o = (|operand_b_i) ? '0 : operand_a_i;
      default: result_o = '0;
    endcase
  end

endmodule

// File: verilog/ex_unit_int_alu.sv
`include "ex_unit_macros.svh"

module ex_unit_int_alu (
  input  logic [`EX_UNIT_XLEN-1:0] operand_a_i,
  input  logic [`EX_UNIT_XLEN-1:0] operand_b_i,
  input  ex_unit_pkg::alu_op_e     operation_i,
  output logic [`EX_UNIT_XLEN-1:0] result_o,
  output logic                     branch_res_o
);

  logic                     negate_b;
  logic [`EX_UNIT_XLEN-1:0] adder_op_a;
  logic [`EX_UNIT_XLEN:0]   op_b_neg;
  logic [`EX_UNIT_XLEN:0]   adder_sum;
  logic [`EX_UNIT_XLEN-1:0] adder_result;
  logic                     adder_zero;
  logic                     cmp_signed;
  logic                     less;
  logic                     shift_left;
  logic                     shift_arith;
  logic [`EX_UNIT_XLEN-1:0] operand_a_rev;
  logic [`EX_UNIT_XLEN-1:0] shift_in;
  logic [`EX_UNIT_XLEN:0]   shift_right;
  logic [`EX_UNIT_XLEN-1:0] shift_left_res;
  logic [`EX_UNIT_XLEN-1:0] shift_result;

  // -------------------------------------------------------------------
  // Adder
  // -------------------------------------------------------------------
  always_comb begin
    case (operation_i)
      ex_unit_pkg::SUB, ex_unit_pkg::EQ, ex_unit_pkg::NE,
      ex_unit_pkg::ANDN, ex_unit_pkg::ORN, ex_unit_pkg::XNOR: negate_b = 1'b1;
      default: negate_b = 1'b0;
    endcase
  end

  // Shift-add pre-shifts operand A
  always_comb begin
    case (operation_i)
      ex_unit_pkg::SH1ADD: adder_op_a = operand_a_i << 1;
      ex_unit_pkg::SH2ADD: adder_op_a = operand_a_i << 2;
      ex_unit_pkg::SH3ADD: adder_op_a = operand_a_i << 3;
      default:             adder_op_a = operand_a_i;
    endcase
  end

  // Extra low bit carries the +1 of the two's complement
  assign op_b_neg     = {operand_b_i, 1'b0} ^ {(`EX_UNIT_XLEN+1){negate_b}};
  assign adder_sum    = {adder_op_a, 1'b1} + op_b_neg;
  assign adder_result = adder_sum[`EX_UNIT_XLEN:1];
  assign adder_zero   = ~|adder_result;

  // -------------------------------------------------------------------
  // Comparator
  // -------------------------------------------------------------------
  assign cmp_signed = (operation_i == ex_unit_pkg::SLTS) ||
                      (operation_i == ex_unit_pkg::LTS)  ||
                      (operation_i == ex_unit_pkg::GES);

  assign less = $signed({cmp_signed & operand_a_i[`EX_UNIT_XLEN-1], operand_a_i}) <
                $signed({cmp_signed & operand_b_i[`EX_UNIT_XLEN-1], operand_b_i});

  always_comb begin
    case (operation_i)
      ex_unit_pkg::EQ:                   branch_res_o = adder_zero;
      ex_unit_pkg::NE:                   branch_res_o = ~adder_zero;
      ex_unit_pkg::LTS, ex_unit_pkg::LTU: branch_res_o = less;
      ex_unit_pkg::GES, ex_unit_pkg::GEU: branch_res_o = ~less;
      default:                           branch_res_o = 1'b1;
    endcase
  end

  // -------------------------------------------------------------------
  // Shifter
  // -------------------------------------------------------------------
  assign shift_left  = (operation_i == ex_unit_pkg::SLL);
  assign shift_arith = (operation_i == ex_unit_pkg::SRA);

  // Left shift as a right shift of the reversed operand
  assign shift_in    = shift_left ? operand_a_rev : operand_a_i;
  assign shift_right = $unsigned($signed({shift_arith & shift_in[`EX_UNIT_XLEN-1], shift_in})
                                 >>> operand_b_i[4:0]);

  always_comb begin
    for (int i = 0; i < `EX_UNIT_XLEN; i++) begin
      operand_a_rev[i]  = operand_a_i[`EX_UNIT_XLEN-1-i];
      shift_left_res[i] = shift_right[`EX_UNIT_XLEN-1-i];
    end
  end

  assign shift_result = shift_left ? shift_left_res : shift_right[`EX_UNIT_XLEN-1:0];

  // Result mux
  always_comb begin
    case (operation_i)
      ex_unit_pkg::ANDL, ex_unit_pkg::ANDN: result_o = operand_a_i & op_b_neg[`EX_UNIT_XLEN:1];
      ex_unit_pkg::ORL, ex_unit_pkg::ORN:   result_o = operand_a_i | op_b_neg[`EX_UNIT_XLEN:1];
      ex_unit_pkg::XORL, ex_unit_pkg::XNOR: result_o = operand_a_i ^ op_b_neg[`EX_UNIT_XLEN:1];
      ex_unit_pkg::ADD, ex_unit_pkg::SUB, ex_unit_pkg::SH1ADD,
      ex_unit_pkg::SH2ADD, ex_unit_pkg::SH3ADD: result_o = adder_result;
      ex_unit_pkg::SLL, ex_unit_pkg::SRL, ex_unit_pkg::SRA: result_o = shift_result;
      ex_unit_pkg::SLTS, ex_unit_pkg::SLTU: result_o = {{(`EX_UNIT_XLEN-1){1'b0}}, less};
      default: result_o = '0;
    endcase
  end

endmodule

// File: verilog/ex_unit_pkg.sv
package ex_unit_pkg;

  // Operation codes as written to the OP register
  typedef enum logic [5:0] {
    // Integer ALU
    ADD       = 6'd0,
    SUB       = 6'd1,
    XORL      = 6'd2,
    ORL       = 6'd3,
    ANDL      = 6'd4,
    ANDN      = 6'd5,
    ORN       = 6'd6,
    XNOR      = 6'd7,
    SLL       = 6'd8,
    SRL       = 6'd9,
    SRA       = 6'd10,
    SLTS      = 6'd11,
    SLTU      = 6'd12,
    SH1ADD    = 6'd13,
    SH2ADD    = 6'd14,
    SH3ADD    = 6'd15,
    // Branch compares
    EQ        = 6'd16,
    NE        = 6'd17,
    LTS       = 6'd18,
    LTU       = 6'd19,
    GES       = 6'd20,
    GEU       = 6'd21,
    // Bit manipulation
    MAX       = 6'd32,
    MAXU      = 6'd33,
    MIN       = 6'd34,
    MINU      = 6'd35,
    CLZ       = 6'd36,
    CTZ       = 6'd37,
    CPOP      = 6'd38,
    SEXTB     = 6'd39,
    SEXTH     = 6'd40,
    ZEXTH     = 6'd41,
    ROL       = 6'd42,
    ROR       = 6'd43,
    ORCB      = 6'd44,
    REV8      = 6'd45,
    BSET      = 6'd46,
    BCLR      = 6'd47,
    BINV      = 6'd48,
    BEXT      = 6'd49,
    // Conditional zero
    CZERO_EQZ = 6'd50,
    CZERO_NEZ = 6'd51
  } alu_op_e;

  typedef enum logic [1:0] {
    INT      = 2'd0,
    BITMANIP = 2'd1,
    ILLEGAL  = 2'd2
  } op_class_e;

  // Which unit produces the result of an operation
  function automatic op_class_e op_class(alu_op_e op);
    if (op <= GEU) begin
      op_class = INT;
    end else if (op >= MAX && op <= CZERO_NEZ) begin
      op_class = BITMANIP;
    end else begin
      op_class = ILLEGAL;
    end
  endfunction

endpackage

// File: verilog/ex_unit_result.sv
`include "ex_unit_macros.svh"

module ex_unit_result (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     start_i,
  input  logic                     clear_i,
  input  ex_unit_pkg::alu_op_e     operation_i,
  input  logic [`EX_UNIT_XLEN-1:0] int_result_i,
  input  logic                     branch_res_i,
  input  logic [`EX_UNIT_XLEN-1:0] bm_result_i,
  output logic [`EX_UNIT_XLEN-1:0] result_o,
  output logic [`EX_UNIT_XLEN-1:0] status_o
);

  logic done_q;
  logic branch_q;
  logic illegal_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_o  <= '0;
      done_q    <= 1'b0;
      branch_q  <= 1'b0;
      illegal_q <= 1'b0;
    end else if (start_i) begin
      done_q    <= 1'b1;
      branch_q  <= branch_res_i;
      illegal_q <= 1'b0;
      case (ex_unit_pkg::op_class(operation_i))
        ex_unit_pkg::INT:      result_o <= int_result_i;
        ex_unit_pkg::BITMANIP: result_o <= bm_result_i;
        default: begin
          result_o  <= '0;
          illegal_q <= 1'b1;
        end
      endcase
    end else if (clear_i) begin
      done_q <= 1'b0;
    end
  end

  // Status bits: done, branch, illegal
  assign status_o = {{(`EX_UNIT_XLEN-3){1'b0}}, illegal_q, branch_q, done_q};

  a_start_pulse : assert property (@(posedge clk_i) disable iff (reset_i)
    start_i |=> !start_i);

endmodule

// File: verilog/ex_unit_wb_regs.sv
`include "ex_unit_macros.svh"

module ex_unit_wb_regs (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  logic [`EX_UNIT_AW-1:0]     wb_adr_i,
  input  logic [`EX_UNIT_XLEN-1:0]   wb_dat_i,
  input  logic [`EX_UNIT_XLEN/8-1:0] wb_sel_i,
  output logic [`EX_UNIT_XLEN-1:0]   wb_dat_o,
  output logic                       wb_ack_o,
  input  logic [`EX_UNIT_XLEN-1:0]   result_i,
  input  logic [`EX_UNIT_XLEN-1:0]   status_i,
  output logic [`EX_UNIT_XLEN-1:0]   operand_a_o,
  output logic [`EX_UNIT_XLEN-1:0]   operand_b_o,
  output ex_unit_pkg::alu_op_e       operation_o,
  output logic                       start_o,
  output logic                       clear_o
);

  logic                     req;
  logic                     wr;
  logic [`EX_UNIT_XLEN-1:0] rdata;

  // New request, not yet acknowledged
  assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr  = req & wb_we_i;

  // -------------------------------------------------------------------
  // Handshake and control pulses
  // -------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_ack_o <= 1'b0;
      start_o  <= 1'b0;
      clear_o  <= 1'b0;
    end else begin
      wb_ack_o <= req;
      start_o  <= wr && (wb_adr_i == `EX_UNIT_REG_OP);
      clear_o  <= wr && (wb_adr_i == `EX_UNIT_REG_OPA || wb_adr_i == `EX_UNIT_REG_OPB);
    end
  end

  // -------------------------------------------------------------------
  // Host registers
  // -------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      operand_a_o <= '0;
      operand_b_o <= '0;
      operation_o <= ex_unit_pkg::ADD;
    end else if (wr) begin
      case (wb_adr_i)
        `EX_UNIT_REG_OPA: begin
          for (int i = 0; i < `EX_UNIT_XLEN/8; i++) begin
            if (wb_sel_i[i]) begin
              operand_a_o[8*i +: 8] <= wb_dat_i[8*i +: 8];
            end
          end
        end
        `EX_UNIT_REG_OPB: begin
          for (int i = 0; i < `EX_UNIT_XLEN/8; i++) begin
            if (wb_sel_i[i]) begin
              operand_b_o[8*i +: 8] <= wb_dat_i[8*i +: 8];
            end
          end
        end
        `EX_UNIT_REG_OP: operation_o <= ex_unit_pkg::alu_op_e'(wb_dat_i[5:0]);
        // RES and STAT ignore writes
        default: ;
      endcase
    end
  end

  // Read mux
  always_comb begin
    case (wb_adr_i)
      `EX_UNIT_REG_OPA:  rdata = operand_a_o;
      `EX_UNIT_REG_OPB:  rdata = operand_b_o;
      `EX_UNIT_REG_OP:   rdata = {{(`EX_UNIT_XLEN-6){1'b0}}, operation_o};
      `EX_UNIT_REG_RES:  rdata = result_i;
      `EX_UNIT_REG_STAT: rdata = status_i;
      default:           rdata = '0;
    endcase
  end

  // Read data is valid together with ack
  always_ff @(posedge clk_i) begin
    if (req) begin
      wb_dat_o <= rdata;
    end
  end

  a_ack_single : assert property (@(posedge clk_i) disable iff (reset_i)
    wb_ack_o |=> !wb_ack_o);

  a_ack_after_req : assert property (@(posedge clk_i) disable iff (reset_i)
    wb_ack_o |-> $past(wb_cyc_i & wb_stb_i));

endmodule
